// ==== design/apbCmpSlave.sv ====
// APB slave holding the compare operands and condition code, with vector readback and branchTaken
`timescale 1ns/1ps

module apbCmpSlave (
	input logic pclk,
	input logic arstN,
	input logic [apbRegPkg::AddrWidth-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [apbRegPkg::DataWidth-1:0] pwdata,
	output logic [apbRegPkg::DataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic branchTaken,
	cmpIf.regs bus
);

	// Phase seen in the previous cycle
	apbRegPkg::apbPhaseE phase;
	apbRegPkg::apbPhaseE phaseNow;
	logic access;
	logic mapped;
	logic readOnly;
	logic badAccess;
	logic wrOk;
	logic [cmpPkg::OperandWidth-1:0] opAReg;
	logic [cmpPkg::OperandWidth-1:0] opBReg;
	cmpPkg::condCodeE condCode;
	logic [apbRegPkg::DataWidth-1:0] rdMux;

	// ========================================
	// Phase tracking
	// ========================================

	always_comb begin
		if (psel && !penable) begin
			phaseNow = apbRegPkg::phSetup;
		end else if (psel && penable) begin
			phaseNow = apbRegPkg::phAccess;
		end else begin
			phaseNow = apbRegPkg::phIdle;
		end
	end

	always_ff @(posedge pclk or negedge arstN) begin
		if (!arstN) begin
			phase <= apbRegPkg::phIdle;
		end else begin
			phase <= phaseNow;
		end
	end

	// An access cycle only counts when it follows a setup cycle
	assign access = (phaseNow == apbRegPkg::phAccess) && (phase == apbRegPkg::phSetup);

	// No wait states
	assign pready = 1'b1;

	// ========================================
	// Address decode
	// ========================================

	assign readOnly = (paddr == apbRegPkg::AddrCondVec) || (paddr == apbRegPkg::AddrBranch);
	assign mapped = readOnly || (paddr == apbRegPkg::AddrOpA) ||
		(paddr == apbRegPkg::AddrOpB) || (paddr == apbRegPkg::AddrCondCode);

	// Unmapped addresses fail either way, read-only ones only on a write
	assign badAccess = !mapped || (pwrite && readOnly);
	assign pslverr = access && badAccess;
	assign wrOk = access && pwrite && !badAccess;

	// ========================================
	// Registers
	// ========================================

	always_ff @(posedge pclk or negedge arstN) begin
		if (!arstN) begin
			opAReg <= '0;
			opBReg <= '0;
			condCode <= cmpPkg::condEq;
			bus.opValid <= 1'b0;
		end else begin
			// Strobe the unit on the edge after an operand write
			bus.opValid <= wrOk &&
				((paddr == apbRegPkg::AddrOpA) || (paddr == apbRegPkg::AddrOpB));
			if (wrOk && (paddr == apbRegPkg::AddrOpA)) begin
				opAReg <= pwdata;
			end
			if (wrOk && (paddr == apbRegPkg::AddrOpB)) begin
				opBReg <= pwdata;
			end
			if (wrOk && (paddr == apbRegPkg::AddrCondCode)) begin
				condCode <= cmpPkg::condCodeE'(pwdata[$bits(cmpPkg::condCodeE)-1:0]);
			end
		end
	end

	assign bus.opA = opAReg;
	assign bus.opB = opBReg;

	// The condition code doubles as the bit index
	assign branchTaken = bus.conds[condCode];

	// ========================================
	// Read path
	// ========================================

	always_comb begin
		case (paddr)
			apbRegPkg::AddrOpA: rdMux = opAReg;
			apbRegPkg::AddrOpB: rdMux = opBReg;
			apbRegPkg::AddrCondCode: begin
				rdMux = {{(apbRegPkg::DataWidth - $bits(cmpPkg::condCodeE)){1'b0}}, condCode};
			end
			apbRegPkg::AddrCondVec: rdMux = bus.conds;
			apbRegPkg::AddrBranch: rdMux = {{(apbRegPkg::DataWidth - 1){1'b0}}, branchTaken};
			default: rdMux = '0;
		endcase
	end

	// Data only shows during a read access, zero otherwise
	assign prdata = (access && !pwrite) ? rdMux : '0;

endmodule

// ==== design/apbRegPkg.sv ====
// APB register map and bus phase encoding for the compare unit front end
package apbRegPkg;

	// Byte address width of the slave
	localparam int AddrWidth = 8;
	// Read and write data width
	localparam int DataWidth = 32;

	// ========================================
	// Register map
	// ========================================

	localparam logic [AddrWidth-1:0] AddrOpA = 8'h00;
	localparam logic [AddrWidth-1:0] AddrOpB = 8'h04;
	localparam logic [AddrWidth-1:0] AddrCondCode = 8'h08;
	// Read-only, writing it is an error
	localparam logic [AddrWidth-1:0] AddrCondVec = 8'h0C;
	// Read-only, bit 0 holds branchTaken
	localparam logic [AddrWidth-1:0] AddrBranch = 8'h10;

	// Phase of the bus as seen in a given cycle
	typedef enum logic [1:0] {
		phIdle,
		phSetup,
		phAccess
	} apbPhaseE;

endpackage

// ==== design/cmpConditions.sv ====
// Condition unit: builds the 32-bit condition vector from two operands and registers it on opValid
`timescale 1ns/1ps

module cmpConditions (
	input logic clk,
	input logic arstN,
	cmpIf.unit bus
);

	logic [cmpPkg::OperandWidth-1:0] a;
	logic [cmpPkg::OperandWidth-1:0] b;
	logic [cmpPkg::CondWidth-1:0] condNext;
	logic fEq;
	logic fLt;
	logic fMagEq;
	logic fNan;

	assign a = bus.opA;
	assign b = bus.opB;

	fpCompare32 fpCmp (
		.a(a),
		.b(b),
		.eq(fEq),
		.lt(fLt),
		.magEq(fMagEq),
		.nan(fNan)
	);

	// ========================================
	// Vector build
	// ========================================

	always_comb begin
		// Integer ordering, signed and unsigned
		condNext[cmpPkg::condEq] = (a == b);
		condNext[cmpPkg::condLt] = ($signed(a) < $signed(b));
		condNext[cmpPkg::condLe] = ($signed(a) <= $signed(b));
		condNext[cmpPkg::condLtu] = (a < b);
		condNext[cmpPkg::condLeu] = (a <= b);
		// Tests on operand A alone
		condNext[cmpPkg::condOdd] = a[0];
		condNext[cmpPkg::condZero] = (a == '0);
		condNext[cmpPkg::condNeg] = a[cmpPkg::OperandWidth-1];
		// Complements of the lower eight
		condNext[cmpPkg::condNe] = (a != b);
		condNext[cmpPkg::condGe] = ($signed(a) >= $signed(b));
		condNext[cmpPkg::condGt] = ($signed(a) > $signed(b));
		condNext[cmpPkg::condGeu] = (a >= b);
		condNext[cmpPkg::condGtu] = (a > b);
		condNext[cmpPkg::condEven] = ~a[0];
		condNext[cmpPkg::condNonZero] = (a != '0);
		condNext[cmpPkg::condAlways] = 1'b1;

		// Float conditions; eq and lt are already false under NaN.
		// Ordered forms are false when either operand is NaN
		condNext[cmpPkg::condFeq] = fEq;
		condNext[cmpPkg::condFmagEq] = fMagEq;
		condNext[cmpPkg::condFgt] = !fNan & !fEq & !fLt;
		condNext[cmpPkg::condFge] = !fNan & !fLt;
		condNext[cmpPkg::condFlt] = fLt;
		condNext[cmpPkg::condFle] = fEq | fLt;
		condNext[cmpPkg::condFne] = !fNan & !fEq;
		// Unordered forms are true when either operand is NaN
		condNext[cmpPkg::condFugt] = fNan | (!fEq & !fLt);
		condNext[cmpPkg::condFuge] = fNan | !fLt;
		condNext[cmpPkg::condFult] = fNan | fLt;
		condNext[cmpPkg::condFule] = fNan | fEq | fLt;
		condNext[cmpPkg::condFuneq] = fNan & !fEq;
		condNext[cmpPkg::condFord] = !fNan;
		condNext[cmpPkg::condFunord] = fNan;

		// Reserved
		condNext[cmpPkg::condRes30] = 1'b0;
		condNext[cmpPkg::condRes31] = 1'b0;
	end

	// ========================================
	// Vector register
	// ========================================

	// The operands clear to zero, so the vector starts at the zero-operand value
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			bus.conds <= cmpPkg::CondsReset;
		end else if (bus.opValid) begin
			bus.conds <= condNext;
		end
	end

endmodule

// ==== design/cmpIf.sv ====
// Link between the APB register block and the condition unit, instantiated in the top level
`timescale 1ns/1ps

interface cmpIf;

	// Operands as last written over APB
	logic [cmpPkg::OperandWidth-1:0] opA;
	logic [cmpPkg::OperandWidth-1:0] opB;
	// One-cycle strobe after either operand was written
	logic opValid;
	// Registered condition vector
	logic [cmpPkg::CondWidth-1:0] conds;

	// Register side owns the operands and reads back the vector
	modport regs (
		output opA,
		output opB,
		output opValid,
		input conds
	);

	// Condition unit side
	modport unit (
		input opA,
		input opB,
		input opValid,
		output conds
	);

endinterface

// ==== design/cmpPkg.sv ====
// Compare-path definitions shared by the condition unit and the APB front end
package cmpPkg;

	// ========================================
	// Widths
	// ========================================

	// Operands are single-precision floats or 32-bit integers
	localparam int OperandWidth = 32;
	// One bit per condition code, two of them reserved
	localparam int CondWidth = 32;

	// Vector value for both operands zero, loaded into the unit at reset.
	// Integer eq, le, leu, zero, ge, geu, even and always are set, and so are
	// float eq, magEq, ge, uge, le, ule and ordered
	localparam logic [CondWidth-1:0] CondsReset = 32'h1333_AA55;

	// ========================================
	// Condition codes
	// ========================================

	// Each code is also the index of its bit in the condition vector
	typedef enum logic [4:0] {
		// Integer conditions, bits 0 to 15
		condEq, condLt, condLe, condLtu,
		condLeu, condOdd, condZero, condNeg,
		condNe, condGe, condGt, condGeu,
		condGtu, condEven, condNonZero, condAlways,
		// Float conditions, bits 16 to 29
		condFeq, condFmagEq, condFgt, condFugt,
		condFge, condFuge, condFlt, condFult,
		condFle, condFule, condFne, condFuneq,
		condFord, condFunord,
		// Always zero
		condRes30, condRes31
	} condCodeE;

endpackage

// ==== design/cmpTop.sv ====
// Top level of the compare condition unit with plain APB ports and the branchTaken output
`timescale 1ns/1ps

module cmpTop (
	input logic pclk,
	input logic arstN,
	input logic [apbRegPkg::AddrWidth-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [apbRegPkg::DataWidth-1:0] pwdata,
	output logic [apbRegPkg::DataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic branchTaken
);

	// Operands, their strobe and the vector between the two blocks
	cmpIf cmpBus ();

	// APB registers and branch selection
	apbCmpSlave slave (
		.pclk(pclk),
		.arstN(arstN),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.branchTaken(branchTaken),
		.bus(cmpBus.regs)
	);

	// Integer and float conditions, one registered step
	cmpConditions conditions (
		.clk(pclk),
		.arstN(arstN),
		.bus(cmpBus.unit)
	);

endmodule

// ==== design/fpCompare32.sv ====
// Single-precision comparator feeding the float half of the condition vector
`timescale 1ns/1ps

module fpCompare32 (
	input logic [31:0] a,
	input logic [31:0] b,
	output logic eq,
	output logic lt,
	output logic magEq,
	output logic nan
);

	logic aNan;
	logic bNan;
	logic aZero;
	logic bZero;
	logic [30:0] aMag;
	logic [30:0] bMag;

	// Magnitude is everything below the sign bit
	assign aMag = a[30:0];
	assign bMag = b[30:0];

	// All-ones exponent with a non-zero mantissa is a NaN, quiet or signalling
	assign aNan = (a[30:23] == 8'hFF) && (a[22:0] != 23'd0);
	assign bNan = (b[30:23] == 8'hFF) && (b[22:0] != 23'd0);
	assign nan = aNan | bNan;

	// Either signed zero
	assign aZero = (aMag == 31'd0);
	assign bZero = (bMag == 31'd0);

	// Bit-equal or both zero, so +0 and -0 compare equal
	assign eq = !nan && ((a == b) || (aZero && bZero));

	// Sign ignored
	assign magEq = !nan && (aMag == bMag);

	// Sign-magnitude ordering
	always_comb begin
		if (nan || (aZero && bZero)) begin
			lt = 1'b0;
		end else if (a[31] != b[31]) begin
			// The negative operand is the smaller one, a -0 included
			lt = a[31];
		end else if (a[31]) begin
			// Both negative, the larger magnitude is smaller
			lt = (aMag > bMag);
		end else begin
			lt = (aMag < bMag);
		end
	end

endmodule

// ==== dv/cmpTb.sv ====
// Testbench for the compare unit: APB traffic checked against a vector model, plus bound checks
`timescale 1ns/1ps

module cmpTb;

	localparam int ClkPeriod = 10;
	localparam logic [31:0] Seed = 32'hbd6285aa;
	localparam int NumCorner = 7;
	localparam int NumRandom = 12;
	localparam int NumCodes = 12;
	// Two after reset, four per operand pair, three per code, six for error responses
	localparam int NumTransfers = 2 + 4 * (NumCorner + NumRandom) + 3 * NumCodes + 6;
	localparam int WatchdogCycles = NumTransfers * 20 + 200;

	logic pclk;
	logic arstN;
	logic [apbRegPkg::AddrWidth-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [apbRegPkg::DataWidth-1:0] pwdata;
	logic [apbRegPkg::DataWidth-1:0] prdata;
	logic pready;
	logic pslverr;
	logic branchTaken;

	// Operands and code the DUT should hold right now
	logic [31:0] curA;
	logic [31:0] curB;
	logic [4:0] curCode;
	logic [31:0] randA;
	logic [31:0] randB;

	// Equal, sign-differing, signed zeros, quiet NaN, infinities, -1 against 1, both negative
	logic [31:0] cornerA [NumCorner] = '{32'h1234_5678, 32'h8000_0001, 32'h0000_0000,
		32'h7FC0_0000, 32'h7F80_0000, 32'hBF80_0000, 32'hC000_0000};
	logic [31:0] cornerB [NumCorner] = '{32'h1234_5678, 32'h0000_0001, 32'h8000_0000,
		32'h3F80_0000, 32'hFF80_0000, 32'h3F80_0000, 32'hBF80_0000};
	logic [4:0] codes [NumCodes] = '{cmpPkg::condEq, cmpPkg::condLt, cmpPkg::condOdd,
		cmpPkg::condNeg, cmpPkg::condAlways, cmpPkg::condFeq, cmpPkg::condFmagEq,
		cmpPkg::condFugt, cmpPkg::condFult, cmpPkg::condFuneq, cmpPkg::condFunord,
		cmpPkg::condRes30};

	cmpTop uut (.*);

	initial begin
		pclk = 1'b0;
		forever begin
			#(ClkPeriod / 2) pclk = ~pclk;
		end
	end

	// ========================================
	// Checking helpers
	// ========================================

	task automatic abortRun();
		$display("Test failed");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
			abortRun();
		end
	endtask

	// Integer bits from signed and unsigned compares, float bits from a signed ordering key
	function automatic logic [31:0] expectedConds(input logic [31:0] a, input logic [31:0] b);
		logic [31:0] v;
		int sa;
		int sb;
		longint ka;
		longint kb;
		logic nan;
		logic feq;
		logic flt;
		logic fgt;
		sa = a;
		sb = b;
		v = '0;
		v[0] = (a == b);
		v[1] = (sa < sb);
		v[2] = (sa <= sb);
		v[3] = (a < b);
		v[4] = (a <= b);
		v[5] = a[0];
		v[6] = (a == 32'd0);
		v[7] = a[31];
		// Bits 8 to 14 negate bits 0 to 6
		v[14:8] = ~v[6:0];
		v[15] = 1'b1;
		nan = (&a[30:23] && |a[22:0]) || (&b[30:23] && |b[22:0]);
		// Negative values get a negated magnitude, so both zeros land on key 0
		ka = {33'd0, a[30:0]};
		kb = {33'd0, b[30:0]};
		if (a[31]) ka = -ka;
		if (b[31]) kb = -kb;
		feq = !nan && (ka == kb);
		flt = !nan && (ka < kb);
		fgt = !nan && (ka > kb);
		v[16] = feq;
		v[17] = !nan && (a[30:0] == b[30:0]);
		v[18] = fgt;
		v[19] = nan | fgt;
		v[20] = feq | fgt;
		v[21] = nan | feq | fgt;
		v[22] = flt;
		v[23] = nan | flt;
		v[24] = flt | feq;
		v[25] = nan | flt | feq;
		v[26] = flt | fgt;
		v[27] = nan;
		v[28] = !nan;
		v[29] = nan;
		return v;
	endfunction

	// ========================================
	// APB stimulus
	// ========================================

	// Setup then access cycle; the response is sampled mid access cycle
	task automatic apbTransfer(input logic [7:0] addr, input logic write,
		input logic [31:0] data, input logic expErr);
		logic [31:0] rdata;
		logic err;
		@(posedge pclk);
		#1;
		paddr = addr;
		pwrite = write;
		pwdata = write ? data : 32'd0;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge pclk);
		#1;
		penable = 1'b1;
		@(negedge pclk);
		rdata = prdata;
		err = pslverr;
		@(posedge pclk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		checkValue($sformatf("pslverr @%h", addr), 32'(err), 32'(expErr));
		if (!write) checkValue($sformatf("prdata @%h", addr), rdata, data);
	endtask

	task automatic checkBranch();
		logic [31:0] vec;
		vec = expectedConds(curA, curB);
		apbTransfer(apbRegPkg::AddrBranch, 1'b0, 32'(vec[curCode]), 1'b0);
		@(negedge pclk);
		checkValue("branchTaken", 32'(branchTaken), 32'(vec[curCode]));
	endtask

	task automatic applyOperands(input logic [31:0] a, input logic [31:0] b);
		apbTransfer(apbRegPkg::AddrOpA, 1'b1, a, 1'b0);
		apbTransfer(apbRegPkg::AddrOpB, 1'b1, b, 1'b0);
		curA = a;
		curB = b;
		apbTransfer(apbRegPkg::AddrCondVec, 1'b0, expectedConds(a, b), 1'b0);
		checkBranch();
	endtask

	task automatic selectCode(input logic [4:0] code);
		apbTransfer(apbRegPkg::AddrCondCode, 1'b1, 32'(code), 1'b0);
		curCode = code;
		apbTransfer(apbRegPkg::AddrCondCode, 1'b0, 32'(code), 1'b0);
		checkBranch();
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		void'($urandom(Seed));
		arstN = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		curA = '0;
		curB = '0;
		curCode = cmpPkg::condEq;
		repeat (10) @(posedge pclk);
		#1;
		arstN = 1'b1;
		// Zero operands and code condEq out of reset
		apbTransfer(apbRegPkg::AddrCondVec, 1'b0, expectedConds('0, '0), 1'b0);
		checkBranch();
		for (int i = 0; i < NumCorner; i++) applyOperands(cornerA[i], cornerB[i]);
		// Mix of plain random, equal, sign-flipped and NaN-exponent operands
		for (int i = 0; i < NumRandom; i++) begin
			randA = $urandom;
			randB = $urandom;
			if (i % 4 == 0) randB = randA;
			if (i % 4 == 1) randB = randA ^ 32'h8000_0000;
			if (i % 6 == 5) randA[30:23] = 8'hFF;
			applyOperands(randA, randB);
		end
		for (int i = 0; i < NumCodes; i++) selectCode(codes[i]);
		// Refused writes and unmapped addresses, then the state must be unchanged
		apbTransfer(apbRegPkg::AddrCondVec, 1'b1, 32'hFFFF_FFFF, 1'b1);
		apbTransfer(apbRegPkg::AddrBranch, 1'b1, 32'h0000_0001, 1'b1);
		apbTransfer(8'h14, 1'b0, 32'h0000_0000, 1'b1);
		apbTransfer(8'h40, 1'b1, 32'h0000_1234, 1'b1);
		apbTransfer(apbRegPkg::AddrCondVec, 1'b0, expectedConds(curA, curB), 1'b0);
		apbTransfer(apbRegPkg::AddrCondCode, 1'b0, 32'(curCode), 1'b0);
		@(posedge pclk);
		if (uut.checks.failCount == 0) begin
			$display("Test passed");
			$finish;
		end else begin
			abortRun();
		end
	end

	// A bound assertion firing ends the run at once
	initial begin
		wait (uut.checks.failCount != 0);
		$display("A bound assertion failed at %0t", $time);
		abortRun();
	end

	initial begin
		#(WatchdogCycles * ClkPeriod);
		$display("Watchdog expired after %0d cycles without finishing", WatchdogCycles);
		abortRun();
	end

endmodule

// ==== dv/cmpTop_assertions.sv ====
// Concurrent checks on the compare unit, attached to the top level through bind
`timescale 1ns/1ps

module cmpTopAssertions (
	input logic pclk,
	input logic arstN,
	input logic [apbRegPkg::AddrWidth-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [apbRegPkg::DataWidth-1:0] pwdata,
	input logic pready,
	input logic pslverr,
	input logic branchTaken,
	input logic opValid,
	input logic [cmpPkg::CondWidth-1:0] conds,
	input logic [4:0] condCode
);

	// Count of failed checks, watched by the testbench
	int unsigned failCount = 0;
	logic readOnly;
	logic mapped;
	// Condition code as last written over APB, kept apart from the slave register
	logic [4:0] codeModel;

	assign readOnly = (paddr == apbRegPkg::AddrCondVec) || (paddr == apbRegPkg::AddrBranch);
	assign mapped = readOnly || (paddr == apbRegPkg::AddrOpA) ||
		(paddr == apbRegPkg::AddrOpB) || (paddr == apbRegPkg::AddrCondCode);

	// Follows condition code writes seen on the bus
	always_ff @(posedge pclk or negedge arstN) begin
		if (!arstN) begin
			codeModel <= '0;
		end else if (psel && penable && pwrite && (paddr == apbRegPkg::AddrCondCode)) begin
			codeModel <= pwdata[4:0];
		end
	end

	// ========================================
	// Vector and branch
	// ========================================

	// The vector only moves on the edge that samples the operand strobe
	condsHold: assert property (@(posedge pclk) disable iff (!arstN)
		!opValid |=> $stable(conds))
	else begin
		failCount++;
		$error("Condition vector changed without an operand strobe");
	end

	// The output is always the vector bit picked by the code written over APB
	branchSelect: assert property (@(posedge pclk) disable iff (!arstN)
		branchTaken == conds[codeModel])
	else begin
		failCount++;
		$error("branchTaken does not match the selected vector bit");
	end

	// ========================================
	// APB responses
	// ========================================

	// No wait states
	readyInAccess: assert property (@(posedge pclk) disable iff (!arstN)
		(psel && penable) |-> pready)
	else begin
		failCount++;
		$error("pready low in an access cycle");
	end

	// Error only for unmapped addresses or writes to read-only registers
	errorResponse: assert property (@(posedge pclk) disable iff (!arstN)
		pslverr == (psel && penable && (!mapped || (pwrite && readOnly))))
	else begin
		failCount++;
		$error("pslverr does not match the address decode");
	end

	// A refused write leaves the code and the vector alone
	readOnlyWrite: assert property (@(posedge pclk) disable iff (!arstN)
		(psel && penable && pwrite && readOnly) |=> ($stable(condCode) && $stable(conds)))
	else begin
		failCount++;
		$error("Write to a read-only register changed the unit state");
	end

endmodule

bind cmpTop cmpTopAssertions checks (
	.pclk(pclk),
	.arstN(arstN),
	.paddr(paddr),
	.psel(psel),
	.penable(penable),
	.pwrite(pwrite),
	.pwdata(pwdata),
	.pready(pready),
	.pslverr(pslverr),
	.branchTaken(branchTaken),
	.opValid(cmpBus.opValid),
	.conds(cmpBus.conds),
	.condCode(slave.condCode)
);

// ==== filelist.f ====
design/cmpPkg.sv
design/apbRegPkg.sv
design/cmpIf.sv
design/fpCompare32.sv
design/cmpConditions.sv
design/apbCmpSlave.sv
design/cmpTop.sv
dv/cmpTop_assertions.sv
dv/cmpTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the compare unit testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cmpTb -f filelist.f -o cmpSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Keep running past an assertion error so the testbench can report it
output=$(./obj_dir/cmpSim +verilator+error+limit+100)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
